// ==== design/cache_pkg.sv ====
/*
 * Cache package
 * Line geometry, address fields, fixed AXI burst fields and the
 * shared types of the single-line direct-mapped data cache
 */
package cache_pkg;

    // ------------------------------------------------------------------
    // Line geometry and address split
    // ------------------------------------------------------------------
    localparam int LINE_WORDS = 16;
    localparam int OFFSET_W   = 2;
    localparam int INDEX_W    = 4;
    // Tag is everything above word index and byte offset
    localparam int TAG_W      = 32 - INDEX_W - OFFSET_W;
    localparam int BURST_LEN  = LINE_WORDS - 1;

    typedef logic [31:0]        addr_t;
    typedef logic [31:0]        word_t;
    typedef logic [3:0]         strb_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [TAG_W-1:0]   tag_t;

    // ------------------------------------------------------------------
    // AXI field types and constant burst fields
    // ------------------------------------------------------------------
    typedef logic [1:0] axi_resp_t;
    typedef logic [7:0] axi_len_t;
    typedef logic [2:0] axi_size_t;
    typedef logic [1:0] axi_burst_t;
    typedef logic [3:0] axi_id_t;

    localparam axi_len_t   AXI_LEN        = axi_len_t'(BURST_LEN);
    // 4 bytes per beat
    localparam axi_size_t  AXI_SIZE_WORD  = 3'b010;
    localparam axi_burst_t AXI_BURST_INCR = 2'b01;
    localparam axi_id_t    AXI_ID_ZERO    = '0;
    localparam axi_resp_t  AXI_RESP_OKAY  = 2'b00;
    localparam strb_t      STRB_FULL      = 4'b1111;

    // Miss handling states
    typedef enum logic [1:0] {IDLE, WRITEBACK, REFILL} cache_state_t;

endpackage

// ==== design/burst_req_if.sv ====
/*
 * Burst request link between cache controller and AXI burst engine
 * One write-back or refill request per start strobe
 */
`timescale 1ns/10ps

interface burst_req_if
    import cache_pkg::*;
();

    // Request, from the controller
    logic   start;
    logic   is_write;
    addr_t  base;

    // Progress and refill data, from the engine
    logic   busy;
    logic   done;
    index_t beat_index;
    logic   rbeat;
    word_t  rdata;
    // Qualified by done
    logic   resp_err;

    modport ctrl (
        output start, is_write, base,
        input  busy, done, beat_index, rbeat, rdata, resp_err
    );

    modport engine (
        input  start, is_write, base,
        output busy, done, beat_index, rbeat, rdata, resp_err
    );

endinterface

// ==== design/cache_line_ram.sv ====
/*
 * Cache line storage
 * LINE_WORDS words, asynchronous read, byte-masked synchronous write
 */
`timescale 1ns/10ps

module cache_line_ram
    import cache_pkg::*;
(
    input  logic   aclk,
    // Read port
    input  index_t rd_index,
    output word_t  rd_data,
    // Write port, shared by CPU merges and refill beats
    input  logic   wr_en,
    input  index_t wr_index,
    input  word_t  wr_data,
    input  strb_t  wr_strb
);

    word_t mem [LINE_WORDS];

    // Combinational read for zero-latency hits
    assign rd_data = mem[rd_index];

    // ------------------------------------------------------------------
    // Byte merge write
    // ------------------------------------------------------------------
    always_ff @(posedge aclk) begin
        if (wr_en) begin
            for (int b = 0; b < $bits(strb_t); b++) begin
                // Only enabled lanes change
                if (wr_strb[b]) begin
                    mem[wr_index][8*b +: 8] <= wr_data[8*b +: 8];
                end
            end
        end
    end

endmodule

// ==== design/cache_ctrl.sv ====
/*
 * Cache controller
 * Holds tag, valid and dirty state, detects hits, raises stall and
 * sequences write-back and refill bursts on a miss
 */
`timescale 1ns/10ps

module cache_ctrl
    import cache_pkg::*;
(
    input  logic      aclk,
    input  logic      rst_n,
    // CPU request
    input  addr_t     address,
    input  word_t     write_data,
    input  strb_t     byte_enable,
    input  logic      read_enable,
    input  logic      write_enable,
    output logic      stall,
    output logic      bus_error,
    // Line RAM control
    output index_t    ram_rd_index,
    output index_t    ram_wr_index,
    output logic      ram_wr_en,
    output word_t     ram_wr_data,
    output strb_t     ram_wr_strb,
    // Burst engine request
    burst_req_if.ctrl burst
);

    cache_state_t state;
    cache_state_t state_d;
    tag_t         line_tag;
    logic         line_valid;
    logic         line_dirty;
    logic         err_q;

    tag_t         req_tag;
    index_t       req_index;
    logic         wr_req;
    logic         any_req;
    logic         hit;
    logic         miss;
    logic         cpu_wr_hit;
    logic         refill_done;

    // ------------------------------------------------------------------
    // Request decode and hit detection
    // ------------------------------------------------------------------
    assign req_tag   = address[31 -: TAG_W];
    assign req_index = address[OFFSET_W +: INDEX_W];

    // Write with no byte lanes is no request at all
    assign wr_req  = write_enable & (|byte_enable);
    assign any_req = read_enable | wr_req;

    assign hit  = line_valid && (line_tag == req_tag);
    assign miss = any_req & ~hit;

    // Stall from the request cycle of a miss until back in IDLE
    assign stall = (state != IDLE) | miss;

    assign cpu_wr_hit  = (state == IDLE) && hit && wr_req;
    assign refill_done = (state == REFILL) && burst.done;
    assign bus_error   = err_q;

    // ------------------------------------------------------------------
    // Miss FSM and burst requests
    // ------------------------------------------------------------------
    always_comb begin
        state_d        = state;
        burst.start    = 1'b0;
        burst.is_write = 1'b0;
        // Refill base by default, block aligned
        burst.base     = {req_tag, {(INDEX_W + OFFSET_W){1'b0}}};
        case (state)
            IDLE: begin
                if (miss && !burst.busy) begin
                    burst.start    = 1'b1;
                    burst.is_write = line_dirty;
                    if (line_dirty) begin
                        // Old block goes back first
                        burst.base = {line_tag, {(INDEX_W + OFFSET_W){1'b0}}};
                        state_d    = WRITEBACK;
                    end else begin
                        state_d = REFILL;
                    end
                end
            end
            WRITEBACK: begin
                // Refill issued in the same cycle the write-back ends
                if (burst.done && !burst.busy) begin
                    burst.start = 1'b1;
                    state_d     = REFILL;
                end
            end
            REFILL: begin
                if (burst.done) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    // ------------------------------------------------------------------
    // Line RAM port steering
    // ------------------------------------------------------------------
    // Write-back walks the line with the engine beat counter
    assign ram_rd_index = (state == WRITEBACK) ? burst.beat_index : req_index;

    always_comb begin
        if (state == REFILL) begin
            ram_wr_en    = burst.rbeat;
            ram_wr_index = burst.beat_index;
            ram_wr_data  = burst.rdata;
            ram_wr_strb  = STRB_FULL;
        end else begin
            // CPU merge on write hit
            ram_wr_en    = cpu_wr_hit;
            ram_wr_index = req_index;
            ram_wr_data  = write_data;
            ram_wr_strb  = byte_enable;
        end
    end

    // ------------------------------------------------------------------
    // State registers
    // ------------------------------------------------------------------
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            state      <= IDLE;
            line_valid <= 1'b0;
            line_dirty <= 1'b0;
            err_q      <= 1'b0;
        end else begin
            state <= state_d;
            if (refill_done) begin
                line_valid <= 1'b1;
                line_dirty <= 1'b0;
            end else if (cpu_wr_hit) begin
                line_dirty <= 1'b1;
            end
            // Sticky until reset
            if (burst.done && burst.resp_err) begin
                err_q <= 1'b1;
            end
        end
    end

    // New tag takes effect with the last refill beat
    always_ff @(posedge aclk) begin
        if (refill_done) begin
            line_tag <= req_tag;
        end
    end

endmodule

// ==== design/axi_burst_engine.sv ====
/*
 * AXI burst engine
 * Runs one full-line INCR burst per request, write-back on AW/W/B or
 * refill on AR/R, and counts beats through the line
 */
`timescale 1ns/10ps

module axi_burst_engine
    import cache_pkg::*;
(
    input  logic        aclk,
    input  logic        rst_n,
    // Line data for write-back beats
    input  word_t       wdata,
    burst_req_if.engine burst,
    // Write address and data
    output addr_t       awaddr,
    output logic        awvalid,
    input  logic        awready,
    output word_t       wdata_out,
    output logic        wlast,
    output logic        wvalid,
    input  logic        wready,
    // Write response
    input  axi_resp_t   bresp,
    input  logic        bvalid,
    output logic        bready,
    // Read address and data
    output addr_t       araddr,
    output logic        arvalid,
    input  logic        arready,
    input  word_t       rdata_in,
    input  logic        rlast,
    input  logic        rvalid,
    output logic        rready
);

    typedef enum logic [1:0] {PH_IDLE, PH_ADDR, PH_DATA, PH_RESP} phase_t;

    phase_t phase_q;
    phase_t phase_d;
    index_t beat_q;
    index_t beat_d;
    logic   is_write_q;
    addr_t  addr_q;
    logic   load;

    // ------------------------------------------------------------------
    // Channel outputs
    // ------------------------------------------------------------------
    assign awaddr  = addr_q;
    assign araddr  = addr_q;
    assign awvalid = (phase_q == PH_ADDR) && is_write_q;
    assign arvalid = (phase_q == PH_ADDR) && !is_write_q;

    assign wdata_out = wdata;
    assign wvalid    = (phase_q == PH_DATA) && is_write_q;
    assign wlast     = wvalid && (beat_q == index_t'(LINE_WORDS - 1));
    // Response wait follows the last W beat
    assign bready    = (phase_q == PH_RESP);
    assign rready    = (phase_q == PH_DATA) && !is_write_q;

    // ------------------------------------------------------------------
    // Controller side
    // ------------------------------------------------------------------
    assign burst.beat_index = beat_q;
    assign burst.rbeat      = rvalid && rready;
    assign burst.rdata      = rdata_in;
    // B handshake for a write, last R handshake for a read
    assign burst.done       = ((phase_q == PH_RESP) && bvalid) || (burst.rbeat && rlast);
    assign burst.resp_err   = (phase_q == PH_RESP) && (bresp != AXI_RESP_OKAY);
    // Drops in the done cycle so a follow-on request can start
    assign burst.busy       = (phase_q != PH_IDLE) && !burst.done;

    assign load = burst.start && !burst.busy;

    // Phase sequence and beat counter
    always_comb begin
        phase_d = phase_q;
        beat_d  = beat_q;
        case (phase_q)
            PH_IDLE: phase_d = PH_IDLE;
            PH_ADDR: begin
                if ((awvalid && awready) || (arvalid && arready)) begin
                    phase_d = PH_DATA;
                end
            end
            PH_DATA: begin
                if (wvalid && wready) begin
                    beat_d = beat_q + index_t'(1);
                    if (wlast) begin
                        phase_d = PH_RESP;
                    end
                end
                if (burst.rbeat) begin
                    beat_d = beat_q + index_t'(1);
                    if (rlast) begin
                        phase_d = PH_IDLE;
                    end
                end
            end
            PH_RESP: begin
                if (bvalid) begin
                    phase_d = PH_IDLE;
                end
            end
            default: phase_d = PH_IDLE;
        endcase
        // New request restarts from beat 0
        if (load) begin
            phase_d = PH_ADDR;
            beat_d  = '0;
        end
    end

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            phase_q <= PH_IDLE;
            beat_q  <= '0;
        end else begin
            phase_q <= phase_d;
            beat_q  <= beat_d;
        end
    end

    // Request capture
    always_ff @(posedge aclk) begin
        if (load) begin
            is_write_q <= burst.is_write;
            addr_q     <= burst.base;
        end
    end

endmodule

// ==== design/cache_top.sv ====
/*
 * Single-line direct-mapped data cache, top level
 * CPU load/store port on one side, AXI master on the other
 */
`timescale 1ns/10ps

module cache_top
    import cache_pkg::*;
(
    input  logic       aclk,
    input  logic       rst_n,
    // CPU port
    input  addr_t      address,
    input  word_t      write_data,
    input  strb_t      byte_enable,
    input  logic       read_enable,
    input  logic       write_enable,
    output word_t      read_data,
    output logic       stall,
    output logic       bus_error,
    // AXI write address
    output axi_id_t    awid,
    output addr_t      awaddr,
    output axi_len_t   awlen,
    output axi_size_t  awsize,
    output axi_burst_t awburst,
    output logic       awvalid,
    input  logic       awready,
    // AXI write data and response
    output word_t      wdata,
    output strb_t      wstrb,
    output logic       wlast,
    output logic       wvalid,
    input  logic       wready,
    input  axi_resp_t  bresp,
    input  logic       bvalid,
    output logic       bready,
    // AXI read address and data
    output axi_id_t    arid,
    output addr_t      araddr,
    output axi_len_t   arlen,
    output axi_size_t  arsize,
    output axi_burst_t arburst,
    output logic       arvalid,
    input  logic       arready,
    input  word_t      rdata,
    input  logic       rlast,
    input  logic       rvalid,
    output logic       rready
);

    index_t ram_rd_index;
    index_t ram_wr_index;
    logic   ram_wr_en;
    word_t  ram_wr_data;
    strb_t  ram_wr_strb;
    word_t  ram_rd_data;

    burst_req_if burst ();

    // ------------------------------------------------------------------
    // Fixed burst fields, full line per burst
    // ------------------------------------------------------------------
    assign awid    = AXI_ID_ZERO;
    assign arid    = AXI_ID_ZERO;
    assign awlen   = AXI_LEN;
    assign arlen   = AXI_LEN;
    assign awsize  = AXI_SIZE_WORD;
    assign arsize  = AXI_SIZE_WORD;
    assign awburst = AXI_BURST_INCR;
    assign arburst = AXI_BURST_INCR;
    // Byte masking is done inside the line
    assign wstrb   = STRB_FULL;

    // Hit data straight from the line read port
    assign read_data = ram_rd_data;

    cache_line_ram i_line_ram (
        .aclk     (aclk),
        .rd_index (ram_rd_index),
        .rd_data  (ram_rd_data),
        .wr_en    (ram_wr_en),
        .wr_index (ram_wr_index),
        .wr_data  (ram_wr_data),
        .wr_strb  (ram_wr_strb)
    );

    cache_ctrl i_ctrl (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .address      (address),
        .write_data   (write_data),
        .byte_enable  (byte_enable),
        .read_enable  (read_enable),
        .write_enable (write_enable),
        .stall        (stall),
        .bus_error    (bus_error),
        .ram_rd_index (ram_rd_index),
        .ram_wr_index (ram_wr_index),
        .ram_wr_en    (ram_wr_en),
        .ram_wr_data  (ram_wr_data),
        .ram_wr_strb  (ram_wr_strb),
        .burst        (burst.ctrl)
    );

    axi_burst_engine i_engine (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .wdata     (ram_rd_data),
        .burst     (burst.engine),
        .awaddr    (awaddr),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata_out (wdata),
        .wlast     (wlast),
        .wvalid    (wvalid),
        .wready    (wready),
        .bresp     (bresp),
        .bvalid    (bvalid),
        .bready    (bready),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata_in  (rdata),
        .rlast     (rlast),
        .rvalid    (rvalid),
        .rready    (rready)
    );

endmodule

// ==== verif/axi_mem_model.sv ====
/*
 * Behavioral AXI slave memory
 * 256 words, full-line INCR bursts, pseudo-random ready and valid gaps,
 * burst counters and SLVERR on writes to one block
 */
`timescale 1ns/10ps

module axi_mem_model
    import cache_pkg::*;
#(
    parameter int ERR_BLOCK = 3
) (
    input  logic      aclk,
    input  logic      rst_n,
    // Write address, data and response
    input  addr_t     awaddr,
    input  logic      awvalid,
    output logic      awready,
    input  word_t     wdata,
    input  logic      wlast,
    input  logic      wvalid,
    output logic      wready,
    output axi_resp_t bresp,
    output logic      bvalid,
    input  logic      bready,
    // Read address and data
    input  addr_t     araddr,
    input  logic      arvalid,
    output logic      arready,
    output word_t     rdata,
    output logic      rlast,
    output logic      rvalid,
    input  logic      rready,
    // Traffic counters
    output int        ar_count,
    output int        aw_count,
    output int        w_beats
);

    localparam axi_resp_t RESP_SLVERR = 2'b10;

    // Contents preloaded by the testbench
    word_t       mem [256];
    logic [31:0] rnd;
    logic [7:0]  wr_ptr;
    logic [7:0]  rd_ptr;
    logic        w_active;
    logic        r_active;

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    assign rdata = mem[rd_ptr];
    // Bursts are block aligned, so the last beat sits at word 15
    assign rlast = (rd_ptr[3:0] == 4'(LINE_WORDS - 1));

    always @(posedge aclk) begin
        if (!rst_n) begin
            rnd      <= 32'd82735;
            awready  <= 1'b0;
            wready   <= 1'b0;
            arready  <= 1'b0;
            bvalid   <= 1'b0;
            bresp    <= AXI_RESP_OKAY;
            rvalid   <= 1'b0;
            w_active <= 1'b0;
            r_active <= 1'b0;
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            ar_count <= 0;
            aw_count <= 0;
            w_beats  <= 0;
        end else begin
            rnd <= next_rand(rnd);
            // Each ready is low about one cycle in four
            awready <= !w_active && !bvalid && (rnd[17:16] != 2'b00);
            wready  <= (rnd[19:18] != 2'b00);
            arready <= !r_active && (rnd[21:20] != 2'b00);

            // ---------------------------------------------------------
            // Write side
            // ---------------------------------------------------------
            if (awvalid && awready) begin
                w_active <= 1'b1;
                wr_ptr   <= awaddr[9:2];
                aw_count <= aw_count + 1;
            end
            if (w_active && wvalid && wready) begin
                mem[wr_ptr] <= wdata;
                wr_ptr      <= wr_ptr + 8'd1;
                w_beats     <= w_beats + 1;
                if (wlast) begin
                    w_active <= 1'b0;
                    bvalid   <= 1'b1;
                    // Data is still stored on the error block
                    bresp    <= (int'(wr_ptr[7:4]) == ERR_BLOCK) ? RESP_SLVERR : AXI_RESP_OKAY;
                end
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end

            // ---------------------------------------------------------
            // Read side
            // ---------------------------------------------------------
            if (arvalid && arready) begin
                r_active <= 1'b1;
                rd_ptr   <= araddr[9:2];
                ar_count <= ar_count + 1;
            end
            if (rvalid && rready) begin
                rd_ptr <= rd_ptr + 8'd1;
                rvalid <= !rlast && (rnd[23:22] != 2'b00);
                if (rlast) begin
                    r_active <= 1'b0;
                end
            end else if (r_active && !rvalid) begin
                // Random gap before the next beat, then held
                rvalid <= (rnd[23:22] != 2'b00);
            end
        end
    end

endmodule

// ==== verif/cache_properties.sv ====
/*
 * Cache top level protocol assertions
 * Stall after reset, AXI valid stability, no read traffic during a write-back
 */
`timescale 1ns/10ps

module cache_properties (
    input logic aclk,
    input logic rst_n,
    input logic stall,
    input logic awvalid,
    input logic awready,
    input logic wvalid,
    input logic wready,
    input logic arvalid,
    input logic arready,
    input logic rready
);

    // No request is pending straight out of reset
    a_stall_after_reset: assert property (@(posedge aclk) !rst_n |=> !stall)
        else $error("stall high after a reset cycle");

    // ----------------------------------------------------------------------
    // Valids hold until their handshake
    // ----------------------------------------------------------------------
    a_aw_hold: assert property (@(posedge aclk) disable iff (!rst_n)
        awvalid && !awready |=> awvalid)
        else $error("awvalid dropped before awready");

    a_w_hold: assert property (@(posedge aclk) disable iff (!rst_n)
        wvalid && !wready |=> wvalid)
        else $error("wvalid dropped before wready");

    a_ar_hold: assert property (@(posedge aclk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid)
        else $error("arvalid dropped before arready");

    // Write-back and refill never overlap
    a_no_read_in_write: assert property (@(posedge aclk) disable iff (!rst_n)
        (awvalid || wvalid) |-> !(arvalid || rready))
        else $error("read channel active during write-back");

endmodule

bind cache_top cache_properties i_properties (.*);

// ==== verif/cache_tb.sv ====
/*
 * Data cache testbench
 * Applies a table of CPU loads and stores against a shadow memory and
 * checks read data, stall timing, AXI burst counts and bus_error
 */
`timescale 1ns/10ps

module cache_tb
    import cache_pkg::*;
;

    localparam int CLK_PERIOD  = 100;
    localparam int NUM_OPS     = 19;
    localparam int ERR_BLOCK   = 3;
    // Write-back plus refill with generous room for ready stalls
    localparam int MISS_CYCLES = 16 * (2 * LINE_WORDS + 6);
    localparam longint WATCHDOG_NS = longint'(NUM_OPS * (MISS_CYCLES + 4) + 20) * CLK_PERIOD;

    typedef struct packed {
        logic       is_write;
        addr_t      addr;
        word_t      data;
        strb_t      strb;
        logic [1:0] ar_inc;
        logic [1:0] aw_inc;
        logic       err;
    } op_t;

    logic aclk;
    logic rst_n;
    addr_t address;
    word_t write_data;
    strb_t byte_enable;
    logic read_enable;
    logic write_enable;
    word_t read_data;
    logic stall;
    logic bus_error;

    // AXI wires between DUT and memory model
    axi_id_t awid;
    axi_id_t arid;
    addr_t awaddr;
    addr_t araddr;
    axi_len_t awlen;
    axi_len_t arlen;
    axi_size_t awsize;
    axi_size_t arsize;
    axi_burst_t awburst;
    axi_burst_t arburst;
    logic awvalid;
    logic awready;
    word_t wdata;
    strb_t wstrb;
    logic wlast;
    logic wvalid;
    logic wready;
    axi_resp_t bresp;
    logic bvalid;
    logic bready;
    logic arvalid;
    logic arready;
    word_t rdata;
    logic rlast;
    logic rvalid;
    logic rready;
    int ar_count;
    int aw_count;
    int w_beats;

    word_t exp_mem [256];
    op_t   ops [$];
    int    errors;
    int    checks;
    int    cur_blk;

    cache_top i_dut (.*);

    axi_mem_model #(.ERR_BLOCK(ERR_BLOCK)) i_mem (.*);

    always #(CLK_PERIOD / 2) aclk = ~aclk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Byte lanes with a set strobe take the new data
    function automatic word_t merge_bytes(input word_t old, input word_t data, input strb_t strb);
        word_t res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = data[8*b +: 8];
            end
        end
        return res;
    endfunction

    task automatic report_error(input string msg);
        errors++;
        $display("Error at %0d ns: %s", $time, msg);
    endtask

    task automatic add_op(input logic is_write, input addr_t addr, input word_t data,
                          input strb_t strb, input int ar_inc, input int aw_inc,
                          input logic err);
        op_t op;
        op = '{is_write, addr, data, strb, 2'(ar_inc), 2'(aw_inc), err};
        ops.push_back(op);
    endtask

    // Memory model block against the shadow after a write-back
    task automatic check_block(input int blk);
        int a;
        for (int i = 0; i < LINE_WORDS; i++) begin
            a = blk * LINE_WORDS + i;
            checks++;
            if (i_mem.mem[a] !== exp_mem[a]) begin
                report_error($sformatf("write-back word %0d is %h, expected %h",
                                       a, i_mem.mem[a], exp_mem[a]));
            end
        end
    endtask

    // ----------------------------------------------------------------------
    // Fixed AXI burst fields, sampled while a valid is offered
    // ----------------------------------------------------------------------
    always @(negedge aclk) begin
        if (rst_n && awvalid) begin
            checks++;
            if (awid !== 4'd0 || awlen !== 8'(LINE_WORDS - 1) || awsize !== 3'b010 ||
                awburst !== 2'b01 || awaddr[5:0] !== 6'd0) begin
                report_error($sformatf("AW id %0d len %0d size %0d burst %0d addr %h",
                                       awid, awlen, awsize, awburst, awaddr));
            end
        end
        if (rst_n && arvalid) begin
            checks++;
            if (arid !== 4'd0 || arlen !== 8'(LINE_WORDS - 1) || arsize !== 3'b010 ||
                arburst !== 2'b01 || araddr[5:0] !== 6'd0) begin
                report_error($sformatf("AR id %0d len %0d size %0d burst %0d addr %h",
                                       arid, arlen, arsize, arburst, araddr));
            end
        end
        // Every write beat carries all byte lanes
        if (rst_n && wvalid) begin
            checks++;
            if (wstrb !== 4'hF) begin
                report_error($sformatf("wstrb is %h during a W beat", wstrb));
            end
        end
    end

    // ----------------------------------------------------------------------
    // One table row: drive, wait for stall low, check
    // ----------------------------------------------------------------------
    task automatic run_op(input int n, input op_t op);
        int ar_before;
        int aw_before;
        int w_before;
        int word;
        int blk;
        ar_before = ar_count;
        aw_before = aw_count;
        w_before  = w_beats;
        word      = int'(op.addr[9:2]);
        blk       = int'(op.addr[9:6]);
        @(posedge aclk);
        address      <= op.addr;
        write_data   <= op.data;
        byte_enable  <= op.strb;
        read_enable  <= !op.is_write;
        write_enable <= op.is_write;
        @(negedge aclk);
        // Miss raises stall in the request cycle, a hit never does
        checks++;
        if (stall !== (op.ar_inc != 0)) begin
            report_error($sformatf("row %0d stall is %b in request cycle", n, stall));
        end
        while (stall) begin
            @(negedge aclk);
        end
        if (!op.is_write) begin
            checks++;
            if (read_data !== exp_mem[word]) begin
                report_error($sformatf("row %0d read %h at %h, expected %h",
                                       n, read_data, op.addr, exp_mem[word]));
            end
        end
        checks++;
        if ((ar_count - ar_before) != int'(op.ar_inc) ||
            (aw_count - aw_before) != int'(op.aw_inc)) begin
            report_error($sformatf("row %0d AR bursts %0d AW bursts %0d, expected %0d and %0d",
                                   n, ar_count - ar_before, aw_count - aw_before,
                                   op.ar_inc, op.aw_inc));
        end
        checks++;
        if ((w_beats - w_before) != int'(op.aw_inc) * LINE_WORDS) begin
            report_error($sformatf("row %0d W beats %0d", n, w_beats - w_before));
        end
        checks++;
        if (bus_error !== op.err) begin
            report_error($sformatf("row %0d bus_error is %b", n, bus_error));
        end
        if (op.aw_inc != 0) begin
            check_block(cur_blk);
        end
        if (op.ar_inc != 0) begin
            cur_blk = blk;
        end
        // Access completes on this edge
        @(posedge aclk);
        read_enable  <= 1'b0;
        write_enable <= 1'b0;
        if (op.is_write) begin
            exp_mem[word] = merge_bytes(exp_mem[word], op.data, op.strb);
        end
    endtask

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        logic [31:0] seed;
        aclk         = 1'b0;
        rst_n        = 1'b0;
        address      = '0;
        write_data   = '0;
        byte_enable  = '0;
        read_enable  = 1'b0;
        write_enable = 1'b0;
        errors       = 0;
        checks       = 0;
        cur_blk      = 0;
        // Preload model and shadow with the same sequence
        seed = 32'd82735;
        for (int i = 0; i < 256; i++) begin
            seed       = lcg_next(seed);
            i_mem.mem[i] = seed;
            exp_mem[i] = seed;
        end

        // First miss, hits, partial write hit
        add_op(1'b0, 32'h000, '0, 4'h0, 1, 0, 1'b0);
        add_op(1'b0, 32'h004, '0, 4'h0, 0, 0, 1'b0);
        add_op(1'b0, 32'h03C, '0, 4'h0, 0, 0, 1'b0);
        add_op(1'b1, 32'h008, 32'hA5A5_5A5A, 4'b0101, 0, 0, 1'b0);
        add_op(1'b0, 32'h008, '0, 4'h0, 0, 0, 1'b0);
        // Dirty eviction, then zero-strobe write keeps the line clean
        add_op(1'b0, 32'h040, '0, 4'h0, 1, 1, 1'b0);
        add_op(1'b1, 32'h044, 32'hFFFF_FFFF, 4'b0000, 0, 0, 1'b0);
        add_op(1'b0, 32'h044, '0, 4'h0, 0, 0, 1'b0);
        add_op(1'b0, 32'h080, '0, 4'h0, 1, 0, 1'b0);
        add_op(1'b0, 32'h008, '0, 4'h0, 1, 0, 1'b0);
        add_op(1'b1, 32'h00C, 32'hDEAD_BEEF, 4'b1111, 0, 0, 1'b0);
        add_op(1'b1, 32'h010, 32'h1234_5678, 4'b1000, 0, 0, 1'b0);
        add_op(1'b0, 32'h0C4, '0, 4'h0, 1, 1, 1'b0);
        // Write-back into the error block sets sticky bus_error
        add_op(1'b1, 32'h0C8, 32'h0BAD_F00D, 4'b0011, 0, 0, 1'b0);
        add_op(1'b0, 32'h100, '0, 4'h0, 1, 1, 1'b1);
        add_op(1'b0, 32'h104, '0, 4'h0, 0, 0, 1'b1);
        add_op(1'b0, 32'h0C8, '0, 4'h0, 1, 0, 1'b1);
        add_op(1'b0, 32'h3FC, '0, 4'h0, 1, 0, 1'b1);
        add_op(1'b0, 32'h010, '0, 4'h0, 1, 0, 1'b1);

        repeat (3) @(posedge aclk);
        rst_n <= 1'b1;
        repeat (2) @(posedge aclk);

        for (int n = 0; n < ops.size(); n++) begin
            run_op(n, ops[n]);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== cache_top.f ====
design/cache_pkg.sv
design/burst_req_if.sv
design/cache_line_ram.sv
design/cache_ctrl.sv
design/axi_burst_engine.sv
design/cache_top.sv
verif/axi_mem_model.sv
verif/cache_properties.sv
verif/cache_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := cache_tb
FILELIST   := cache_top.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
LOG        := sim.log
FAIL_MSG   := Some tests failed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation FAILED"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
